// File: compile.f
logic/audio_pkg.sv
logic/control_if.sv
logic/control_keys.sv
logic/noise_gate.sv
logic/echo_effect.sv
logic/volume_shifter.sv
logic/audio_path_top.sv
testbench/audio_path_tb.sv

// File: logic/audio_path_top.sv
`timescale 1ns/1ps

module audio_path_top #(
    parameter int SAMPLE_W   = audio_pkg::SAMPLE_W,
    parameter int ECHO_DEPTH = audio_pkg::ECHO_DEPTH
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [3:0]                        pbs,        // pushbuttons
    input  logic [1:0]                        vol,        // quadrature knob
    input  logic signed [SAMPLE_W-1:0]        in_sample,
    input  logic                              in_valid,
    output logic signed [SAMPLE_W-1:0]        out_sample,
    output logic                              out_valid,  // in_valid + 3 cycles
    output logic [audio_pkg::VOL_W-1:0]       volume,
    output logic                              mute,
    output logic                              ptt,
    output logic                              noise_gate,
    output logic                              effect
);

    control_if ctl ();

    logic signed [SAMPLE_W-1:0] gate_sample;  // gate -> echo
    logic                       gate_valid;
    logic signed [SAMPLE_W-1:0] echo_sample;  // echo -> volume
    logic                       echo_valid;

    control_keys control_keys_i (
        .clk (clk),
        .rst (rst),
        .pbs (pbs),
        .vol (vol),
        .ctl (ctl.source)
    );

    noise_gate #(.SAMPLE_W(SAMPLE_W)) noise_gate_i (
        .clk        (clk),
        .rst        (rst),
        .in_sample  (in_sample),
        .in_valid   (in_valid),
        .out_sample (gate_sample),
        .out_valid  (gate_valid),
        .ctl        (ctl.sink)
    );

    echo_effect #(.SAMPLE_W(SAMPLE_W), .ECHO_DEPTH(ECHO_DEPTH)) echo_effect_i (
        .clk        (clk),
        .rst        (rst),
        .in_sample  (gate_sample),
        .in_valid   (gate_valid),
        .out_sample (echo_sample),
        .out_valid  (echo_valid),
        .ctl        (ctl.sink)
    );

    volume_shifter #(.SAMPLE_W(SAMPLE_W)) volume_shifter_i (
        .clk        (clk),
        .rst        (rst),
        .in_sample  (echo_sample),
        .in_valid   (echo_valid),
        .out_sample (out_sample),
        .out_valid  (out_valid),
        .ctl        (ctl.sink)
    );

    // settings brought out for observation
    assign volume     = ctl.volume;
    assign mute       = ctl.mute;
    assign ptt        = ctl.ptt;
    assign noise_gate = ctl.noise_gate;
    assign effect     = ctl.effect;

endmodule

// File: logic/audio_pkg.sv
package audio_pkg;

    // default datapath sizing, overridden through the top level parameters
    localparam int SAMPLE_W   = 16;  // signed audio sample width
    localparam int ECHO_DEPTH = 8;   // echo delay in valid samples

    // volume control
    localparam int VOL_W   = 4;                  // volume counter width
    localparam int VOL_MAX = (1 << VOL_W) - 1;   // full scale, passes samples unshifted

    // noise gate: magnitudes strictly below this are squelched
    localparam int GATE_THRESHOLD = 256;

    // quadrature knob phases, listed in clockwise order
    typedef enum logic [1:0] {
        Q00 = 2'b00,
        Q01 = 2'b01,
        Q11 = 2'b11,
        Q10 = 2'b10
    } quad_t;

    // pushbutton bit positions on pbs
    typedef enum logic [1:0] {
        BTN_PTT    = 2'd0,  // push-to-talk, level
        BTN_MUTE   = 2'd1,  // mute toggle
        BTN_EFFECT = 2'd2,  // echo toggle
        BTN_GATE   = 2'd3   // noise gate toggle
    } btn_e;

endpackage

// File: logic/control_if.sv
`timescale 1ns/1ps

// user settings produced by the key block and read by the sample stages
interface control_if;

    logic [audio_pkg::VOL_W-1:0] volume;  // 0 is quietest, VOL_MAX passes unchanged
    logic                        mute;        // toggled mode
    logic                        ptt;         // level, overrides mute while held
    logic                        noise_gate;  // toggled mode
    logic                        effect;      // toggled mode, enables echo

    // key block owns every setting
    modport source (
        output volume,
        output mute,
        output ptt,
        output noise_gate,
        output effect
    );

    // stages only look
    modport sink (
        input volume,
        input mute,
        input ptt,
        input noise_gate,
        input effect
    );

endinterface

// File: logic/control_keys.sv
`timescale 1ns/1ps

module control_keys (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] pbs,  // raw pushbuttons, indexed by audio_pkg::btn_e
    input  logic [1:0] vol,  // raw quadrature knob
    control_if.source  ctl
);

    logic [3:0] pbs_s1;    // first sync flop
    logic [3:0] pbs_s2;    // second sync flop, safe to use
    logic [3:0] pbs_last;  // s2 one cycle back, for edge detect
    logic [3:0] pbs_rise;  // one-cycle pulse per press

    logic [1:0]       vol_s1;      // first sync flop of the knob
    audio_pkg::quad_t phase_cur;   // synchronized knob phase
    audio_pkg::quad_t phase_last;  // phase seen the cycle before

    logic                        step_cw;   // one valid clockwise step
    logic                        step_acw;  // one valid anticlockwise step
    logic [audio_pkg::VOL_W-1:0] vol_next;

    // two-flop synchronizers, plus the history stage for edge/step compare
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pbs_s1     <= '0;
            pbs_s2     <= '0;
            pbs_last   <= '0;
            vol_s1     <= '0;
            phase_cur  <= audio_pkg::Q00;
            phase_last <= audio_pkg::Q00;
        end else begin
            pbs_s1     <= pbs;
            pbs_s2     <= pbs_s1;
            pbs_last   <= pbs_s2;
            vol_s1     <= vol;
            phase_cur  <= audio_pkg::quad_t'(vol_s1);
            phase_last <= phase_cur;
        end
    end

    assign pbs_rise = pbs_s2 & ~pbs_last;  // held button gives a single pulse

    // mode register, the third stage after the pins
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ctl.mute       <= 1'b0;
            ctl.effect     <= 1'b0;
            ctl.noise_gate <= 1'b0;
            ctl.ptt        <= 1'b0;
        end else begin
            if (pbs_rise[audio_pkg::BTN_MUTE])
                ctl.mute <= ~ctl.mute;
            if (pbs_rise[audio_pkg::BTN_EFFECT])
                ctl.effect <= ~ctl.effect;
            if (pbs_rise[audio_pkg::BTN_GATE])
                ctl.noise_gate <= ~ctl.noise_gate;
            ctl.ptt <= pbs_s2[audio_pkg::BTN_PTT];  // follows level, no toggle
        end
    end

    // gray-code step decode, any two-bit jump falls to default
    always_comb begin
        step_cw  = 1'b0;
        step_acw = 1'b0;
        case ({phase_last, phase_cur})
            {audio_pkg::Q00, audio_pkg::Q01},
            {audio_pkg::Q01, audio_pkg::Q11},
            {audio_pkg::Q11, audio_pkg::Q10},
            {audio_pkg::Q10, audio_pkg::Q00}: step_cw = 1'b1;
            {audio_pkg::Q00, audio_pkg::Q10},
            {audio_pkg::Q10, audio_pkg::Q11},
            {audio_pkg::Q11, audio_pkg::Q01},
            {audio_pkg::Q01, audio_pkg::Q00}: step_acw = 1'b1;
            default: ;  // no movement or illegal jump
        endcase
    end

    // saturating up/down count
    always_comb begin
        vol_next = ctl.volume;
        if (step_cw && (ctl.volume != audio_pkg::VOL_W'(audio_pkg::VOL_MAX)))
            vol_next = ctl.volume + 1'b1;
        else if (step_acw && (ctl.volume != '0))
            vol_next = ctl.volume - 1'b1;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst)
            ctl.volume <= '0;
        else
            ctl.volume <= vol_next;
    end

    // one detent moves one step, a wrap between 0 and 15 would show as a big jump
    a_vol_step: assert property (@(posedge clk) disable iff (rst)
        (int'(ctl.volume) - int'($past(ctl.volume))) inside {-1, 0, 1});

    // both knob bits changing at once is no step in either direction
    a_vol_jump: assert property (@(posedge clk) disable iff (rst)
        ((phase_last ^ phase_cur) == 2'b11) |=> $stable(ctl.volume));

endmodule

// File: logic/echo_effect.sv
`timescale 1ns/1ps

module echo_effect #(
    parameter int SAMPLE_W   = audio_pkg::SAMPLE_W,
    parameter int ECHO_DEPTH = audio_pkg::ECHO_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic signed [SAMPLE_W-1:0] in_sample,
    input  logic                       in_valid,
    output logic signed [SAMPLE_W-1:0] out_sample,
    output logic                       out_valid,
    control_if.sink                    ctl
);

    localparam int PTR_W  = (ECHO_DEPTH > 1) ? $clog2(ECHO_DEPTH) : 1;
    localparam int FILL_W = $clog2(ECHO_DEPTH + 1);  // counts up to ECHO_DEPTH inclusive

    localparam logic signed [SAMPLE_W-1:0] S_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
    localparam logic signed [SAMPLE_W-1:0] S_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

    logic signed [SAMPLE_W-1:0] delay_mem [ECHO_DEPTH];  // ring of past inputs

    logic [PTR_W-1:0]  wr_ptr;  // oldest entry, overwritten next
    logic [FILL_W-1:0] fill;    // valid samples seen, stops at ECHO_DEPTH
    logic              full;

    logic signed [SAMPLE_W-1:0] delayed;  // sample from ECHO_DEPTH valids ago, or 0
    logic signed [SAMPLE_W-1:0] half;
    logic signed [SAMPLE_W:0]   sum;      // one guard bit for overflow
    logic signed [SAMPLE_W-1:0] mixed;

    assign full    = (fill == FILL_W'(ECHO_DEPTH));
    assign delayed = full ? delay_mem[wr_ptr] : '0;  // read before this cycle's write
    assign half    = delayed >>> 1;
    assign sum     = {in_sample[SAMPLE_W-1], in_sample} + {half[SAMPLE_W-1], half};

    // clamp when the guard bit disagrees with the sign
    always_comb begin
        if (sum[SAMPLE_W] != sum[SAMPLE_W-1])
            mixed = sum[SAMPLE_W] ? S_MIN : S_MAX;
        else
            mixed = sum[SAMPLE_W-1:0];
    end

    // ring write and output payload
    always_ff @(posedge clk) begin
        if (in_valid) begin
            delay_mem[wr_ptr] <= in_sample;  // history kept even with effect off
            out_sample        <= ctl.effect ? mixed : in_sample;
        end
    end

    // pointer and fill tracking
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            fill   <= '0;
        end else if (in_valid) begin
            if (wr_ptr == PTR_W'(ECHO_DEPTH - 1))
                wr_ptr <= '0;
            else
                wr_ptr <= wr_ptr + 1'b1;
            if (!full)
                fill <= fill + 1'b1;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    // wrap logic keeps the index inside the ring, matters for non power of two depths
    a_ptr_range: assert property (@(posedge clk) disable iff (rst)
        int'(wr_ptr) < ECHO_DEPTH);

endmodule

// File: logic/noise_gate.sv
`timescale 1ns/1ps

module noise_gate #(
    parameter int SAMPLE_W = audio_pkg::SAMPLE_W
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic signed [SAMPLE_W-1:0] in_sample,
    input  logic                       in_valid,
    output logic signed [SAMPLE_W-1:0] out_sample,
    output logic                       out_valid,
    control_if.sink                    ctl
);

    logic quiet;  // |in_sample| below threshold

    // signed compare both ways, most negative value counts as loud
    assign quiet = (in_sample < audio_pkg::GATE_THRESHOLD) &&
                   (in_sample > -audio_pkg::GATE_THRESHOLD);

    // payload only moves on valid
    always_ff @(posedge clk) begin
        if (in_valid) begin
            if (ctl.noise_gate && quiet)
                out_sample <= '0;       // squelched
            else
                out_sample <= in_sample;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;  // one stage of latency
    end

    // with the gate on, a nonzero output is always at or above the threshold
    a_gate_floor: assert property (@(posedge clk) disable iff (rst)
        (in_valid && ctl.noise_gate) |=>
            ((out_sample == '0) ||
             (out_sample >= audio_pkg::GATE_THRESHOLD) ||
             (out_sample <= -audio_pkg::GATE_THRESHOLD)));

endmodule

// File: logic/volume_shifter.sv
`timescale 1ns/1ps

module volume_shifter #(
    parameter int SAMPLE_W = audio_pkg::SAMPLE_W
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic signed [SAMPLE_W-1:0] in_sample,
    input  logic                       in_valid,
    output logic signed [SAMPLE_W-1:0] out_sample,
    output logic                       out_valid,
    control_if.sink                    ctl
);

    logic [audio_pkg::VOL_W-1:0] shamt;    // attenuation in powers of two
    logic                        silence;  // mute not overridden by ptt
    logic signed [SAMPLE_W-1:0]  scaled;

    assign shamt   = audio_pkg::VOL_W'(audio_pkg::VOL_MAX) - ctl.volume;  // full volume -> 0
    assign silence = ctl.mute && !ctl.ptt;
    assign scaled  = in_sample >>> shamt;  // sign preserved

    always_ff @(posedge clk) begin
        if (in_valid)
            out_sample <= silence ? '0 : scaled;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    // attenuation keeps the sign, negative samples never shift up to zero
    a_sign_kept: assert property (@(posedge clk) disable iff (rst)
        (in_valid && !silence) |=>
            (out_sample[SAMPLE_W-1] == $past(in_sample[SAMPLE_W-1])));

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the audio path testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module audio_path_tb -o audio_path_sim

sim_out="$(./obj_dir/audio_path_sim 2>&1)" || true
echo "$sim_out"

if grep -qF -- '*** TEST PASSED ***' <<< "$sim_out"; then
    exit 0
fi
exit 1

// File: testbench/audio_path_tb.sv
`timescale 1ns/1ps

module audio_path_tb;

    localparam int    SW         = audio_pkg::SAMPLE_W;
    localparam int    VW         = audio_pkg::VOL_W;
    localparam int    CLK_NS     = 4;
    localparam string TESTS_FILE = "testbench/audio_path_tests.txt";

    logic                 clk;
    logic                 rst;
    logic [3:0]           pbs;
    logic [1:0]           vol;
    logic signed [SW-1:0] in_sample;
    logic                 in_valid;
    logic signed [SW-1:0] out_sample;
    logic                 out_valid;
    logic [VW-1:0]        volume;
    logic                 mute;
    logic                 ptt;
    logic                 noise_gate;
    logic                 effect;

    string lines[$];   // stimulus lines, comments already stripped
    bit    loaded;     // releases the watchdog once the line count is known
    int    checks;
    int    value_errors;
    int    other_errors;

    audio_path_top #(
        .SAMPLE_W   (SW),
        .ECHO_DEPTH (audio_pkg::ECHO_DEPTH)
    ) audio_path_top_i (
        .clk        (clk),
        .rst        (rst),
        .pbs        (pbs),
        .vol        (vol),
        .in_sample  (in_sample),
        .in_valid   (in_valid),
        .out_sample (out_sample),
        .out_valid  (out_valid),
        .volume     (volume),
        .mute       (mute),
        .ptt        (ptt),
        .noise_gate (noise_gate),
        .effect     (effect)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // keeps every data line, drops blank lines and # comments
    task automatic read_test_file();
        int    fd;
        string line;
        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the test file %s", TESTS_FILE);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#")
                lines.push_back(line);
        end
        $fclose(fd);
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            value_errors++;
            $display("error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // drive one line on the rising edge, check it half a cycle later
    task automatic apply_line(input int idx);
        int n;
        int f_pbs, f_vol, f_smp, f_val;
        int e_vol, e_mode, e_valid, e_smp;
        n = $sscanf(lines[idx], "%h %h %h %h %h %h %h %h",
                    f_pbs, f_vol, f_smp, f_val, e_vol, e_mode, e_valid, e_smp);
        @(posedge clk);
        if (n != 8) begin
            other_errors++;
            $display("data line %0d of the test file has %0d fields instead of 8", idx, n);
            return;
        end
        pbs       <= f_pbs[3:0];
        vol       <= f_vol[1:0];
        in_sample <= f_smp[SW-1:0];
        in_valid  <= f_val[0];
        @(negedge clk);  // outputs settled, away from the driving edge
        compare_value("volume", e_vol[VW-1:0], volume);
        compare_value("ptt", e_mode[0], ptt);        // mode bits follow the pbs order
        compare_value("mute", e_mode[1], mute);
        compare_value("effect", e_mode[2], effect);
        compare_value("noise_gate", e_mode[3], noise_gate);
        compare_value("out_valid", e_valid[0], out_valid);
        if (e_valid[0])
            compare_value("out_sample", e_smp[SW-1:0], {out_sample});  // concat drops the sign
    endtask

    initial begin
        rst          = 1'b1;
        pbs          = '0;
        vol          = '0;
        in_sample    = '0;
        in_valid     = 1'b0;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        read_test_file();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        foreach (lines[i])
            apply_line(i);
        if (lines.size() == 0) begin
            other_errors++;
            $display("no stimulus lines were read");
        end
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // one line per clock plus reset and slack
    initial begin
        wait (loaded);
        #((lines.size() + 100) * CLK_NS);
        $display("timeout, the run did not end within %0d cycles", lines.size() + 100);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: testbench/audio_path_tests.txt
# pbs vol in_sample in_valid   exp_volume exp_modes(gate,effect,mute,ptt) exp_out_valid exp_out
# hex, one line per clock; expected columns are sampled half a cycle after the line is driven
0 2 0000 0   0 0 0 0000
8 0 0000 0   0 0 0 0000
8 1 0000 0   0 0 0 0000
8 3 0000 0   0 0 0 0000
0 2 0000 0   1 8 0 0000
4 0 0000 0   2 8 0 0000
0 1 0000 0   3 8 0 0000
4 3 0000 0   4 8 0 0000
4 2 0000 0   5 c 0 0000
0 0 0000 0   6 c 0 0000
1 1 0000 0   7 8 0 0000
1 3 0000 0   8 8 0 0000
0 2 0000 0   9 8 0 0000
0 0 0000 0   a 9 0 0000
0 1 0000 0   b 9 0 0000
0 3 0000 0   c 8 0 0000
0 2 00ff 1   d 8 0 0000
8 2 ff01 1   e 8 0 0000
0 2 0100 1   f 8 0 0000
0 2 ff00 1   f 8 1 0000
0 1 1234 1   f 0 1 0000
4 1 abcd 1   f 0 1 0100
0 1 7fff 1   f 0 1 ff00
0 1 0200 1   f 0 1 1234
0 1 0300 1   f 4 1 abcd
0 1 0010 1   f 4 1 7fff
0 1 1000 1   f 4 1 0200
0 1 1000 1   f 4 1 0300
0 1 0100 1   f 4 1 0010
4 1 9000 1   f 4 1 1080
2 1 7000 1   f 4 1 0f80
2 0 4000 1   f 4 1 0a1a
1 2 0000 0   f 0 1 8000
1 2 4000 1   f 2 1 7fff
0 2 0000 0   e 2 1 0000
2 2 4000 1   d 3 0 0000
0 2 8001 1   d 3 1 1000
0 2 0000 0   d 2 0 0000
0 2 0000 0   d 0 1 0000
0 2 0000 0   d 0 1 e000
0 2 0000 0   d 0 0 0000
